//--- common/periph_pkg.sv
package periph_pkg;

	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	// every slave owns a window of 0x20 bytes and sees only the offset bits.
	localparam int WIN_ADDR_W = 5;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_t;

	localparam logic [AXIL_ADDR_W-1:0] SEG_BASE = 8'h00;
	localparam logic [AXIL_ADDR_W-1:0] LED_BASE = 8'h20;

	localparam int SEG_NUM_DIGITS = 6;
	localparam int SEG_IDX_W = $clog2(SEG_NUM_DIGITS);
	localparam int SEG_DIGIT_STRIDE = 4;

	typedef enum logic {
		BIG_ENDIAN,
		LITTLE_ENDIAN
	} endian_t;

	// big endian takes the digit from bits 3:0, little endian from bits 27:24.
	localparam endian_t SEG_ENDIANESS = BIG_ENDIAN;

	localparam int LED_W = 10;
	localparam int SW_W = 10;
	localparam logic [WIN_ADDR_W-1:0] LED_OFF = 5'h00;
	localparam logic [WIN_ADDR_W-1:0] SW_OFF = 5'h04;

endpackage : periph_pkg

//--- seg/hex7seg.sv
`timescale 1ns/1ps

module hex7seg (
	input	logic	[3:0]	digit_i,
	output	logic	[6:0]	seg_o
);

	// segments are active low, bit 0 is segment a and bit 6 is segment g.
	always_comb begin
		case (digit_i)
			4'h0: seg_o = 7'b100_0000;
			4'h1: seg_o = 7'b111_1001;
			4'h2: seg_o = 7'b010_0100;
			4'h3: seg_o = 7'b011_0000;
			4'h4: seg_o = 7'b001_1001;
			4'h5: seg_o = 7'b001_0010;
			4'h6: seg_o = 7'b000_0010;
			4'h7: seg_o = 7'b111_1000;
			4'h8: seg_o = 7'b000_0000;
			4'h9: seg_o = 7'b001_0000;
			4'hA: seg_o = 7'b000_1000;
			4'hB: seg_o = 7'b000_0011;
			4'hC: seg_o = 7'b100_0110;
			4'hD: seg_o = 7'b010_0001;
			4'hE: seg_o = 7'b000_0110;
			default: seg_o = 7'b000_1110;
		endcase
	end

endmodule : hex7seg

//--- seg/seg_axil.sv
`timescale 1ns/1ps

module seg_axil import periph_pkg::*; (
	input	logic	clk,
	input	logic	rst,

	input	logic	cfg_awvalid_i, cfg_wvalid_i, cfg_bready_i, cfg_arvalid_i, cfg_rready_i,
	input	logic	[WIN_ADDR_W-1:0]	cfg_awaddr_i, cfg_araddr_i,
	input	logic	[AXIL_DATA_W-1:0]	cfg_wdata_i,
	// protection bits are accepted and have no effect.
	input	logic	[2:0]	cfg_awprot_i, cfg_arprot_i,
	output	logic	cfg_awready_o, cfg_wready_o, cfg_bvalid_o, cfg_arready_o, cfg_rvalid_o,
	output	axi_resp_t	cfg_bresp_o, cfg_rresp_o,
	output	logic	[AXIL_DATA_W-1:0]	cfg_rdata_o,

	output	logic	[6:0]	hex0_o, hex1_o, hex2_o, hex3_o, hex4_o, hex5_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WDATA,
		S_WRESP,
		S_RRESP
	} state_t;

	state_t state;
	logic [3:0] digits [SEG_NUM_DIGITS];
	logic [WIN_ADDR_W-1:0] wr_off, rd_off;
	logic [3:0] wr_nibble;
	logic [SEG_IDX_W-1:0] wr_idx, rd_idx;
	logic wr_hit, rd_hit;

	// only offsets on a digit stride that name an existing digit are mapped.
	function automatic logic offset_hit(input logic [WIN_ADDR_W-1:0] off);
		return (off % SEG_DIGIT_STRIDE == 0) && (off / SEG_DIGIT_STRIDE < SEG_NUM_DIGITS);
	endfunction

	assign wr_hit = offset_hit(wr_off);
	assign rd_hit = offset_hit(rd_off);
	assign wr_idx = SEG_IDX_W'(wr_off / SEG_DIGIT_STRIDE);
	assign rd_idx = SEG_IDX_W'(rd_off / SEG_DIGIT_STRIDE);

	assign cfg_arready_o = (state == S_IDLE) & cfg_arvalid_i;
	assign cfg_awready_o = (state == S_IDLE) & cfg_awvalid_i & ~cfg_arvalid_i;
	assign cfg_wready_o = cfg_wvalid_i & (cfg_awready_o | (state == S_WDATA));
	assign cfg_bvalid_o = (state == S_WRESP);
	assign cfg_rvalid_o = (state == S_RRESP);
	assign cfg_bresp_o = wr_hit ? RESP_OKAY : RESP_SLVERR;
	assign cfg_rresp_o = rd_hit ? RESP_OKAY : RESP_SLVERR;
	assign cfg_rdata_o = rd_hit ? AXIL_DATA_W'(digits[rd_idx]) : '0;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (cfg_arready_o)
						state <= S_RRESP;
					else if (cfg_awready_o)
						state <= cfg_wready_o ? S_WRESP : S_WDATA;
				end
				S_WDATA: begin
					if (cfg_wready_o)
						state <= S_WRESP;
				end
				S_WRESP: begin
					if (cfg_bready_i)
						state <= S_IDLE;
				end
				S_RRESP: begin
					if (cfg_rready_i)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_awready_o)
			wr_off <= cfg_awaddr_i;
		if (cfg_arready_o)
			rd_off <= cfg_araddr_i;
		if (cfg_wready_o)
			wr_nibble <= (SEG_ENDIANESS == BIG_ENDIAN) ? cfg_wdata_i[3:0] : cfg_wdata_i[27:24];
	end

	// the digit changes when the write response is taken.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < SEG_NUM_DIGITS; i++)
				digits[i] <= 4'h0;
		end else if (cfg_bvalid_o && cfg_bready_i && wr_hit) begin
			digits[wr_idx] <= wr_nibble;
		end
	end

	hex7seg i_hex0 (.digit_i(digits[0]), .seg_o(hex0_o));
	hex7seg i_hex1 (.digit_i(digits[1]), .seg_o(hex1_o));
	hex7seg i_hex2 (.digit_i(digits[2]), .seg_o(hex2_o));
	hex7seg i_hex3 (.digit_i(digits[3]), .seg_o(hex3_o));
	hex7seg i_hex4 (.digit_i(digits[4]), .seg_o(hex4_o));
	hex7seg i_hex5 (.digit_i(digits[5]), .seg_o(hex5_o));

	// one transaction at a time, so a new request only reaches an idle slave.
	req_idle: assert property (@(posedge clk) disable iff (rst)
		(cfg_awvalid_i || cfg_arvalid_i) |-> state == S_IDLE);

endmodule : seg_axil

//--- design/led_axil.sv
`timescale 1ns/1ps

module led_axil import periph_pkg::*; (
	input	logic	clk,
	input	logic	rst,

	input	logic	cfg_awvalid_i, cfg_wvalid_i, cfg_bready_i, cfg_arvalid_i, cfg_rready_i,
	input	logic	[WIN_ADDR_W-1:0]	cfg_awaddr_i, cfg_araddr_i,
	input	logic	[AXIL_DATA_W-1:0]	cfg_wdata_i,
	output	logic	cfg_awready_o, cfg_wready_o, cfg_bvalid_o, cfg_arready_o, cfg_rvalid_o,
	output	axi_resp_t	cfg_bresp_o, cfg_rresp_o,
	output	logic	[AXIL_DATA_W-1:0]	cfg_rdata_o,

	input	logic	[SW_W-1:0]	sw_i,
	output	logic	[LED_W-1:0]	led_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WDATA,
		S_WRESP,
		S_RRESP
	} state_t;

	state_t state;
	logic [WIN_ADDR_W-1:0] wr_off, rd_off;
	logic [LED_W-1:0] wr_led;
	logic [SW_W-1:0] sw_meta, sw_sync;

	assign cfg_arready_o = (state == S_IDLE) & cfg_arvalid_i;
	assign cfg_awready_o = (state == S_IDLE) & cfg_awvalid_i & ~cfg_arvalid_i;
	assign cfg_wready_o = cfg_wvalid_i & (cfg_awready_o | (state == S_WDATA));
	assign cfg_bvalid_o = (state == S_WRESP);
	assign cfg_rvalid_o = (state == S_RRESP);
	// the switch register is read only, so only the LED offset takes writes.
	assign cfg_bresp_o = (wr_off == LED_OFF) ? RESP_OKAY : RESP_SLVERR;
	assign cfg_rresp_o = (rd_off == LED_OFF || rd_off == SW_OFF) ? RESP_OKAY : RESP_SLVERR;
	assign cfg_rdata_o = (rd_off == LED_OFF) ? AXIL_DATA_W'(led_o) :
		(rd_off == SW_OFF) ? AXIL_DATA_W'(sw_sync) : '0;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (cfg_arready_o)
						state <= S_RRESP;
					else if (cfg_awready_o)
						state <= cfg_wready_o ? S_WRESP : S_WDATA;
				end
				S_WDATA: begin
					if (cfg_wready_o)
						state <= S_WRESP;
				end
				S_WRESP: begin
					if (cfg_bready_i)
						state <= S_IDLE;
				end
				S_RRESP: begin
					if (cfg_rready_i)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_awready_o)
			wr_off <= cfg_awaddr_i;
		if (cfg_arready_o)
			rd_off <= cfg_araddr_i;
		if (cfg_wready_o)
			wr_led <= cfg_wdata_i[LED_W-1:0];
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			led_o <= '0;
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= sw_i;
			sw_sync <= sw_meta;
			if (cfg_bvalid_o && cfg_bready_i && wr_off == LED_OFF)
				led_o <= wr_led;
		end
	end

endmodule : led_axil

//--- design/axil_arbiter.sv
`timescale 1ns/1ps

module axil_arbiter import periph_pkg::*; (
	input	logic	clk,
	input	logic	rst,

	input	logic	m0_awvalid_i, m0_wvalid_i, m0_bready_i, m0_arvalid_i, m0_rready_i,
	input	logic	[AXIL_ADDR_W-1:0]	m0_awaddr_i, m0_araddr_i,
	input	logic	[AXIL_DATA_W-1:0]	m0_wdata_i,
	input	logic	[AXIL_STRB_W-1:0]	m0_wstrb_i,
	output	logic	m0_awready_o, m0_wready_o, m0_bvalid_o, m0_arready_o, m0_rvalid_o,
	output	axi_resp_t	m0_bresp_o, m0_rresp_o,
	output	logic	[AXIL_DATA_W-1:0]	m0_rdata_o,

	input	logic	m1_awvalid_i, m1_wvalid_i, m1_bready_i, m1_arvalid_i, m1_rready_i,
	input	logic	[AXIL_ADDR_W-1:0]	m1_awaddr_i, m1_araddr_i,
	input	logic	[AXIL_DATA_W-1:0]	m1_wdata_i,
	input	logic	[AXIL_STRB_W-1:0]	m1_wstrb_i,
	output	logic	m1_awready_o, m1_wready_o, m1_bvalid_o, m1_arready_o, m1_rvalid_o,
	output	axi_resp_t	m1_bresp_o, m1_rresp_o,
	output	logic	[AXIL_DATA_W-1:0]	m1_rdata_o,

	output	logic	bus_awvalid_o, bus_wvalid_o, bus_bready_o, bus_arvalid_o, bus_rready_o,
	output	logic	[AXIL_ADDR_W-1:0]	bus_awaddr_o, bus_araddr_o,
	output	logic	[AXIL_DATA_W-1:0]	bus_wdata_o,
	input	logic	bus_awready_i, bus_wready_i, bus_bvalid_i, bus_arready_i, bus_rvalid_i,
	input	axi_resp_t	bus_bresp_i, bus_rresp_i,
	input	logic	[AXIL_DATA_W-1:0]	bus_rdata_i
);

	typedef enum logic {
		ARB_IDLE,
		ARB_GRANT
	} arb_state_t;

	arb_state_t state;
	// last is the master granted most recently, so in ARB_GRANT it is the owner.
	logic last;
	logic req0, req1, pick1, gnt0, gnt1, done;

	assign req0 = m0_awvalid_i | m0_arvalid_i;
	assign req1 = m1_awvalid_i | m1_arvalid_i;
	assign pick1 = req1 & (~req0 | ~last);
	assign gnt0 = (state == ARB_GRANT) & ~last;
	assign gnt1 = (state == ARB_GRANT) & last;
	assign done = (bus_bvalid_i & bus_bready_o) | (bus_rvalid_i & bus_rready_o);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= ARB_IDLE;
			last <= 1'b1;
		end else if (state == ARB_IDLE) begin
			if (req0 | req1) begin
				state <= ARB_GRANT;
				last <= pick1;
			end
		end else if (done) begin
			state <= ARB_IDLE;
		end
	end

	assign bus_awvalid_o = (gnt0 & m0_awvalid_i) | (gnt1 & m1_awvalid_i);
	assign bus_wvalid_o = (gnt0 & m0_wvalid_i) | (gnt1 & m1_wvalid_i);
	assign bus_bready_o = (gnt0 & m0_bready_i) | (gnt1 & m1_bready_i);
	assign bus_arvalid_o = (gnt0 & m0_arvalid_i) | (gnt1 & m1_arvalid_i);
	assign bus_rready_o = (gnt0 & m0_rready_i) | (gnt1 & m1_rready_i);
	assign bus_awaddr_o = last ? m1_awaddr_i : m0_awaddr_i;
	assign bus_araddr_o = last ? m1_araddr_i : m0_araddr_i;
	assign bus_wdata_o = last ? m1_wdata_i : m0_wdata_i;

	assign m0_awready_o = gnt0 & bus_awready_i;
	assign m0_wready_o = gnt0 & bus_wready_i;
	assign m0_bvalid_o = gnt0 & bus_bvalid_i;
	assign m0_arready_o = gnt0 & bus_arready_i;
	assign m0_rvalid_o = gnt0 & bus_rvalid_i;
	assign m0_bresp_o = bus_bresp_i;
	assign m0_rresp_o = bus_rresp_i;
	assign m0_rdata_o = bus_rdata_i;

	assign m1_awready_o = gnt1 & bus_awready_i;
	assign m1_wready_o = gnt1 & bus_wready_i;
	assign m1_bvalid_o = gnt1 & bus_bvalid_i;
	assign m1_arready_o = gnt1 & bus_arready_i;
	assign m1_rvalid_o = gnt1 & bus_rvalid_i;
	assign m1_bresp_o = bus_bresp_i;
	assign m1_rresp_o = bus_rresp_i;
	assign m1_rdata_o = bus_rdata_i;

	// a response on the bus always belongs to the master that holds the grant.
	grant_held: assert property (@(posedge clk) disable iff (rst)
		(bus_bvalid_i || bus_rvalid_i) |-> state == ARB_GRANT);

	// the slaves only take full-word writes.
	full_word_m0: assert property (@(posedge clk) disable iff (rst)
		m0_wvalid_i |-> &m0_wstrb_i);
	full_word_m1: assert property (@(posedge clk) disable iff (rst)
		m1_wvalid_i |-> &m1_wstrb_i);

endmodule : axil_arbiter

//--- design/axil_decoder.sv
`timescale 1ns/1ps

module axil_decoder import periph_pkg::*; (
	input	logic	clk,
	input	logic	rst,

	input	logic	bus_awvalid_i, bus_wvalid_i, bus_bready_i, bus_arvalid_i, bus_rready_i,
	input	logic	[AXIL_ADDR_W-1:0]	bus_awaddr_i, bus_araddr_i,
	input	logic	[AXIL_DATA_W-1:0]	bus_wdata_i,
	output	logic	bus_awready_o, bus_wready_o, bus_bvalid_o, bus_arready_o, bus_rvalid_o,
	output	axi_resp_t	bus_bresp_o, bus_rresp_o,
	output	logic	[AXIL_DATA_W-1:0]	bus_rdata_o,

	output	logic	seg_awvalid_o, seg_wvalid_o, seg_bready_o, seg_arvalid_o, seg_rready_o,
	output	logic	[WIN_ADDR_W-1:0]	seg_awaddr_o, seg_araddr_o,
	output	logic	[AXIL_DATA_W-1:0]	seg_wdata_o,
	input	logic	seg_awready_i, seg_wready_i, seg_bvalid_i, seg_arready_i, seg_rvalid_i,
	input	axi_resp_t	seg_bresp_i, seg_rresp_i,
	input	logic	[AXIL_DATA_W-1:0]	seg_rdata_i,

	output	logic	led_awvalid_o, led_wvalid_o, led_bready_o, led_arvalid_o, led_rready_o,
	output	logic	[WIN_ADDR_W-1:0]	led_awaddr_o, led_araddr_o,
	output	logic	[AXIL_DATA_W-1:0]	led_wdata_o,
	input	logic	led_awready_i, led_wready_i, led_bvalid_i, led_arready_i, led_rvalid_i,
	input	axi_resp_t	led_bresp_i, led_rresp_i,
	input	logic	[AXIL_DATA_W-1:0]	led_rdata_i
);

	typedef enum logic [1:0] {
		TGT_SEG,
		TGT_LED,
		TGT_NONE
	} target_t;

	function automatic target_t decode(input logic [AXIL_ADDR_W-1:0] addr);
		if (addr[AXIL_ADDR_W-1:WIN_ADDR_W] == SEG_BASE[AXIL_ADDR_W-1:WIN_ADDR_W])
			return TGT_SEG;
		if (addr[AXIL_ADDR_W-1:WIN_ADDR_W] == LED_BASE[AXIL_ADDR_W-1:WIN_ADDR_W])
			return TGT_LED;
		return TGT_NONE;
	endfunction

	target_t aw_tgt, ar_tgt, w_tgt, tgt;
	logic busy, wr_sel, err_aw, err_w, err_ar, err_b, err_r;
	logic aw_hs, ar_hs, resp_hs, seg_resp, led_resp;

	assign aw_tgt = decode(bus_awaddr_i);
	assign ar_tgt = decode(bus_araddr_i);
	// a read wins over a write offered in the same cycle, as in the slaves.
	assign wr_sel = bus_awvalid_i & ~bus_arvalid_i;
	assign w_tgt = busy ? tgt : (wr_sel ? aw_tgt : TGT_NONE);

	assign seg_awvalid_o = ~busy & wr_sel & (aw_tgt == TGT_SEG);
	assign seg_wvalid_o = bus_wvalid_i & (w_tgt == TGT_SEG);
	assign seg_arvalid_o = ~busy & bus_arvalid_i & (ar_tgt == TGT_SEG);
	assign seg_bready_o = bus_bready_i & busy & (tgt == TGT_SEG);
	assign seg_rready_o = bus_rready_i & busy & (tgt == TGT_SEG);
	assign seg_awaddr_o = bus_awaddr_i[WIN_ADDR_W-1:0];
	assign seg_araddr_o = bus_araddr_i[WIN_ADDR_W-1:0];
	assign seg_wdata_o = bus_wdata_i;

	assign led_awvalid_o = ~busy & wr_sel & (aw_tgt == TGT_LED);
	assign led_wvalid_o = bus_wvalid_i & (w_tgt == TGT_LED);
	assign led_arvalid_o = ~busy & bus_arvalid_i & (ar_tgt == TGT_LED);
	assign led_bready_o = bus_bready_i & busy & (tgt == TGT_LED);
	assign led_rready_o = bus_rready_i & busy & (tgt == TGT_LED);
	assign led_awaddr_o = bus_awaddr_i[WIN_ADDR_W-1:0];
	assign led_araddr_o = bus_araddr_i[WIN_ADDR_W-1:0];
	assign led_wdata_o = bus_wdata_i;

	// unmapped addresses are answered here with a decode error.
	assign err_aw = ~busy & wr_sel & (aw_tgt == TGT_NONE);
	assign err_ar = ~busy & bus_arvalid_i & (ar_tgt == TGT_NONE);
	assign err_w = err_aw | (busy & (tgt == TGT_NONE) & ~err_b & ~err_r);

	assign bus_awready_o = seg_awready_i | led_awready_i | err_aw;
	assign bus_wready_o = seg_wready_i | led_wready_i | err_w;
	assign bus_arready_o = seg_arready_i | led_arready_i | err_ar;
	assign bus_bvalid_o = (tgt == TGT_SEG) ? seg_bvalid_i :
		(tgt == TGT_LED) ? led_bvalid_i : err_b;
	assign bus_bresp_o = (tgt == TGT_SEG) ? seg_bresp_i :
		(tgt == TGT_LED) ? led_bresp_i : RESP_DECERR;
	assign bus_rvalid_o = (tgt == TGT_SEG) ? seg_rvalid_i :
		(tgt == TGT_LED) ? led_rvalid_i : err_r;
	assign bus_rresp_o = (tgt == TGT_SEG) ? seg_rresp_i :
		(tgt == TGT_LED) ? led_rresp_i : RESP_DECERR;
	assign bus_rdata_o = (tgt == TGT_SEG) ? seg_rdata_i :
		(tgt == TGT_LED) ? led_rdata_i : '0;

	assign aw_hs = bus_awvalid_i & bus_awready_o;
	assign ar_hs = bus_arvalid_i & bus_arready_o;
	assign resp_hs = (bus_bvalid_o & bus_bready_i) | (bus_rvalid_o & bus_rready_i);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			tgt <= TGT_NONE;
			err_b <= 1'b0;
			err_r <= 1'b0;
		end else begin
			if (aw_hs | ar_hs) begin
				busy <= 1'b1;
				tgt <= ar_hs ? ar_tgt : aw_tgt;
			end else if (resp_hs) begin
				busy <= 1'b0;
			end
			if (bus_wvalid_i & err_w)
				err_b <= 1'b1;
			else if (bus_bready_i)
				err_b <= 1'b0;
			if (err_ar)
				err_r <= 1'b1;
			else if (bus_rready_i)
				err_r <= 1'b0;
		end
	end

	assign seg_resp = seg_bvalid_i | seg_rvalid_i;
	assign led_resp = led_bvalid_i | led_rvalid_i;

	// a slave only answers while it is the registered target, so at most one answers.
	seg_owner: assert property (@(posedge clk) disable iff (rst)
		seg_resp |-> busy && tgt == TGT_SEG);
	led_owner: assert property (@(posedge clk) disable iff (rst)
		led_resp |-> busy && tgt == TGT_LED);

endmodule : axil_decoder

//--- design/periph_top.sv
`timescale 1ns/1ps

module periph_top import periph_pkg::*; (
	input	logic	clk,
	input	logic	rst,

	input	logic	m0_awvalid_i, m0_wvalid_i, m0_bready_i, m0_arvalid_i, m0_rready_i,
	input	logic	[AXIL_ADDR_W-1:0]	m0_awaddr_i, m0_araddr_i,
	input	logic	[AXIL_DATA_W-1:0]	m0_wdata_i,
	input	logic	[AXIL_STRB_W-1:0]	m0_wstrb_i,
	output	logic	m0_awready_o, m0_wready_o, m0_bvalid_o, m0_arready_o, m0_rvalid_o,
	output	axi_resp_t	m0_bresp_o, m0_rresp_o,
	output	logic	[AXIL_DATA_W-1:0]	m0_rdata_o,

	input	logic	m1_awvalid_i, m1_wvalid_i, m1_bready_i, m1_arvalid_i, m1_rready_i,
	input	logic	[AXIL_ADDR_W-1:0]	m1_awaddr_i, m1_araddr_i,
	input	logic	[AXIL_DATA_W-1:0]	m1_wdata_i,
	input	logic	[AXIL_STRB_W-1:0]	m1_wstrb_i,
	output	logic	m1_awready_o, m1_wready_o, m1_bvalid_o, m1_arready_o, m1_rvalid_o,
	output	axi_resp_t	m1_bresp_o, m1_rresp_o,
	output	logic	[AXIL_DATA_W-1:0]	m1_rdata_o,

	input	logic	[SW_W-1:0]	sw_i,
	output	logic	[LED_W-1:0]	led_o,
	output	logic	[6:0]	hex0_o, hex1_o, hex2_o, hex3_o, hex4_o, hex5_o
);

	logic bus_awvalid, bus_wvalid, bus_bready, bus_arvalid, bus_rready;
	logic bus_awready, bus_wready, bus_bvalid, bus_arready, bus_rvalid;
	logic [AXIL_ADDR_W-1:0] bus_awaddr, bus_araddr;
	logic [AXIL_DATA_W-1:0] bus_wdata, bus_rdata;
	axi_resp_t bus_bresp, bus_rresp;

	logic seg_awvalid, seg_wvalid, seg_bready, seg_arvalid, seg_rready;
	logic seg_awready, seg_wready, seg_bvalid, seg_arready, seg_rvalid;
	logic [WIN_ADDR_W-1:0] seg_awaddr, seg_araddr;
	logic [AXIL_DATA_W-1:0] seg_wdata, seg_rdata;
	axi_resp_t seg_bresp, seg_rresp;

	logic led_awvalid, led_wvalid, led_bready, led_arvalid, led_rready;
	logic led_awready, led_wready, led_bvalid, led_arready, led_rvalid;
	logic [WIN_ADDR_W-1:0] led_awaddr, led_araddr;
	logic [AXIL_DATA_W-1:0] led_wdata, led_rdata;
	axi_resp_t led_bresp, led_rresp;

	// the master ports carry the same names here and in the arbiter.
	axil_arbiter i_arbiter (
		.*,
		.bus_awvalid_o(bus_awvalid), .bus_awaddr_o(bus_awaddr), .bus_wvalid_o(bus_wvalid),
		.bus_wdata_o(bus_wdata), .bus_bready_o(bus_bready), .bus_arvalid_o(bus_arvalid),
		.bus_araddr_o(bus_araddr), .bus_rready_o(bus_rready),
		.bus_awready_i(bus_awready), .bus_wready_i(bus_wready), .bus_bvalid_i(bus_bvalid),
		.bus_bresp_i(bus_bresp), .bus_arready_i(bus_arready), .bus_rvalid_i(bus_rvalid),
		.bus_rdata_i(bus_rdata), .bus_rresp_i(bus_rresp)
	);

	axil_decoder i_decoder (
		.clk(clk), .rst(rst),
		.bus_awvalid_i(bus_awvalid), .bus_awaddr_i(bus_awaddr), .bus_wvalid_i(bus_wvalid),
		.bus_wdata_i(bus_wdata), .bus_bready_i(bus_bready), .bus_arvalid_i(bus_arvalid),
		.bus_araddr_i(bus_araddr), .bus_rready_i(bus_rready),
		.bus_awready_o(bus_awready), .bus_wready_o(bus_wready), .bus_bvalid_o(bus_bvalid),
		.bus_bresp_o(bus_bresp), .bus_arready_o(bus_arready), .bus_rvalid_o(bus_rvalid),
		.bus_rdata_o(bus_rdata), .bus_rresp_o(bus_rresp),
		.seg_awvalid_o(seg_awvalid), .seg_awaddr_o(seg_awaddr), .seg_wvalid_o(seg_wvalid),
		.seg_wdata_o(seg_wdata), .seg_bready_o(seg_bready), .seg_arvalid_o(seg_arvalid),
		.seg_araddr_o(seg_araddr), .seg_rready_o(seg_rready),
		.seg_awready_i(seg_awready), .seg_wready_i(seg_wready), .seg_bvalid_i(seg_bvalid),
		.seg_bresp_i(seg_bresp), .seg_arready_i(seg_arready), .seg_rvalid_i(seg_rvalid),
		.seg_rdata_i(seg_rdata), .seg_rresp_i(seg_rresp),
		.led_awvalid_o(led_awvalid), .led_awaddr_o(led_awaddr), .led_wvalid_o(led_wvalid),
		.led_wdata_o(led_wdata), .led_bready_o(led_bready), .led_arvalid_o(led_arvalid),
		.led_araddr_o(led_araddr), .led_rready_o(led_rready),
		.led_awready_i(led_awready), .led_wready_i(led_wready), .led_bvalid_i(led_bvalid),
		.led_bresp_i(led_bresp), .led_arready_i(led_arready), .led_rvalid_i(led_rvalid),
		.led_rdata_i(led_rdata), .led_rresp_i(led_rresp)
	);

	seg_axil i_seg (
		.clk(clk), .rst(rst),
		.cfg_awvalid_i(seg_awvalid), .cfg_awaddr_i(seg_awaddr), .cfg_awprot_i(3'b000),
		.cfg_wvalid_i(seg_wvalid), .cfg_wdata_i(seg_wdata), .cfg_bready_i(seg_bready),
		.cfg_arvalid_i(seg_arvalid), .cfg_araddr_i(seg_araddr), .cfg_arprot_i(3'b000),
		.cfg_rready_i(seg_rready),
		.cfg_awready_o(seg_awready), .cfg_wready_o(seg_wready), .cfg_bvalid_o(seg_bvalid),
		.cfg_bresp_o(seg_bresp), .cfg_arready_o(seg_arready), .cfg_rvalid_o(seg_rvalid),
		.cfg_rdata_o(seg_rdata), .cfg_rresp_o(seg_rresp),
		.hex0_o(hex0_o), .hex1_o(hex1_o), .hex2_o(hex2_o),
		.hex3_o(hex3_o), .hex4_o(hex4_o), .hex5_o(hex5_o)
	);

	led_axil i_led (
		.clk(clk), .rst(rst),
		.cfg_awvalid_i(led_awvalid), .cfg_awaddr_i(led_awaddr), .cfg_wvalid_i(led_wvalid),
		.cfg_wdata_i(led_wdata), .cfg_bready_i(led_bready), .cfg_arvalid_i(led_arvalid),
		.cfg_araddr_i(led_araddr), .cfg_rready_i(led_rready),
		.cfg_awready_o(led_awready), .cfg_wready_o(led_wready), .cfg_bvalid_o(led_bvalid),
		.cfg_bresp_o(led_bresp), .cfg_arready_o(led_arready), .cfg_rvalid_o(led_rvalid),
		.cfg_rdata_o(led_rdata), .cfg_rresp_o(led_rresp),
		.sw_i(sw_i), .led_o(led_o)
	);

endmodule : periph_top

//--- verif/periph_tb.sv
`timescale 1ns/1ps

module periph_tb import periph_pkg::*; ();

	localparam int WAIT_LIMIT = 64;
	localparam int RUN_LIMIT = 5000;

	typedef struct packed {
		logic master;
		logic write;
		logic [AXIL_ADDR_W-1:0] addr;
		logic [AXIL_DATA_W-1:0] wdata;
		axi_resp_t resp;
		logic [AXIL_DATA_W-1:0] rdata;
	} step_t;

	logic clk;
	logic rst;
	logic awvalid [2], wvalid [2], bready [2], arvalid [2], rready [2];
	logic [AXIL_ADDR_W-1:0] awaddr [2], araddr [2];
	logic [AXIL_DATA_W-1:0] wdata [2];
	logic [AXIL_STRB_W-1:0] wstrb [2];
	logic awready [2], wready [2], bvalid [2], arready [2], rvalid [2];
	axi_resp_t bresp [2], rresp [2];
	logic [AXIL_DATA_W-1:0] rdata [2];
	logic [SW_W-1:0] sw;
	logic [LED_W-1:0] led;
	logic [6:0] hex [SEG_NUM_DIGITS];

	// active-low patterns for 0 to F, bit 0 is segment a.
	logic [6:0] seg_table [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};
	logic [3:0] exp_digit [SEG_NUM_DIGITS];
	logic [LED_W-1:0] exp_led;
	time addr_time [2];
	time resp_time [2];
	step_t steps [$];
	integer seed = 32'h496c_9aa4;

	periph_top i_dut (
		.clk(clk), .rst(rst),
		.m0_awvalid_i(awvalid[0]), .m0_wvalid_i(wvalid[0]), .m0_bready_i(bready[0]),
		.m0_arvalid_i(arvalid[0]), .m0_rready_i(rready[0]),
		.m0_awaddr_i(awaddr[0]), .m0_araddr_i(araddr[0]),
		.m0_wdata_i(wdata[0]), .m0_wstrb_i(wstrb[0]),
		.m0_awready_o(awready[0]), .m0_wready_o(wready[0]), .m0_bvalid_o(bvalid[0]),
		.m0_arready_o(arready[0]), .m0_rvalid_o(rvalid[0]),
		.m0_bresp_o(bresp[0]), .m0_rresp_o(rresp[0]), .m0_rdata_o(rdata[0]),
		.m1_awvalid_i(awvalid[1]), .m1_wvalid_i(wvalid[1]), .m1_bready_i(bready[1]),
		.m1_arvalid_i(arvalid[1]), .m1_rready_i(rready[1]),
		.m1_awaddr_i(awaddr[1]), .m1_araddr_i(araddr[1]),
		.m1_wdata_i(wdata[1]), .m1_wstrb_i(wstrb[1]),
		.m1_awready_o(awready[1]), .m1_wready_o(wready[1]), .m1_bvalid_o(bvalid[1]),
		.m1_arready_o(arready[1]), .m1_rvalid_o(rvalid[1]),
		.m1_bresp_o(bresp[1]), .m1_rresp_o(rresp[1]), .m1_rdata_o(rdata[1]),
		.sw_i(sw), .led_o(led),
		.hex0_o(hex[0]), .hex1_o(hex[1]), .hex2_o(hex[2]),
		.hex3_o(hex[3]), .hex4_o(hex[4]), .hex5_o(hex[5])
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
		if (act !== exp)
			abort_run($sformatf("ERR time=%0t signal=%s expected=%s(%b) actual=%s(%b)",
				$time, name, exp.name(), exp, act.name(), act));
	endtask

	task automatic check_data(input string name, input logic [AXIL_DATA_W-1:0] exp,
			input logic [AXIL_DATA_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("ERR time=%0t signal=%s expected=%h actual=%h",
				$time, name, exp, act));
	endtask

	task automatic check_hex(input string name, input logic [6:0] exp, input logic [6:0] act);
		if (act !== exp)
			abort_run($sformatf("ERR time=%0t signal=%s expected=%h actual=%h",
				$time, name, exp, act));
	endtask

	task automatic check_led(input string name, input logic [LED_W-1:0] exp,
			input logic [LED_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("ERR time=%0t signal=%s expected=%h actual=%h",
				$time, name, exp, act));
	endtask

	// digits sit at 4-byte steps below 0x18, the LED register at 0x20.
	function automatic void note_write(input logic [AXIL_ADDR_W-1:0] addr,
			input logic [AXIL_DATA_W-1:0] data);
		if (addr < 8'h18 && addr[1:0] == 2'b00)
			exp_digit[addr[4:2]] = data[3:0];
		else if (addr == 8'h20)
			exp_led = data[LED_W-1:0];
	endfunction

	task automatic check_outputs();
		for (int i = 0; i < SEG_NUM_DIGITS; i++)
			check_hex($sformatf("hex%0d_o", i), seg_table[exp_digit[i]], hex[i]);
		check_led("led_o", exp_led, led);
	endtask

	// one full transaction on master m; hold delays the response ready.
	task automatic bus_access(input int m, input logic write,
			input logic [AXIL_ADDR_W-1:0] addr, input logic [AXIL_DATA_W-1:0] data,
			input int hold, output axi_resp_t resp, output logic [AXIL_DATA_W-1:0] rd_data);
		logic addr_done;
		logic data_done;
		logic resp_done;
		int n;
		@(negedge clk);
		addr_done = 1'b0;
		data_done = ~write;
		resp_done = 1'b0;
		resp = RESP_OKAY;
		rd_data = '0;
		if (write) begin
			awvalid[m] = 1'b1;
			awaddr[m] = addr;
			wvalid[m] = 1'b1;
			wdata[m] = data;
		end else begin
			arvalid[m] = 1'b1;
			araddr[m] = addr;
		end
		n = 0;
		while (!(addr_done && data_done)) begin
			@(posedge clk);
			if (!addr_done && (write ? awready[m] : arready[m])) begin
				addr_done = 1'b1;
				addr_time[m] = $time;
			end
			if (!data_done && wready[m])
				data_done = 1'b1;
			@(negedge clk);
			if (addr_done) begin
				awvalid[m] = 1'b0;
				arvalid[m] = 1'b0;
			end
			if (data_done)
				wvalid[m] = 1'b0;
			n++;
			if (n > WAIT_LIMIT)
				abort_run($sformatf("master %0d timed out on the %s channel", m,
					!addr_done ? (write ? "write address" : "read address") : "write data"));
		end
		n = 0;
		bready[m] = write && (hold == 0);
		rready[m] = !write && (hold == 0);
		while (!resp_done) begin
			@(posedge clk);
			if (write && bvalid[m] && bready[m]) begin
				resp_done = 1'b1;
				resp = bresp[m];
				resp_time[m] = $time;
			end else if (!write && rvalid[m] && rready[m]) begin
				resp_done = 1'b1;
				resp = rresp[m];
				rd_data = rdata[m];
				resp_time[m] = $time;
			end
			@(negedge clk);
			n++;
			if (resp_done) begin
				bready[m] = 1'b0;
				rready[m] = 1'b0;
			end else if (n >= hold) begin
				bready[m] = write;
				rready[m] = !write;
			end
			if (!resp_done && n > hold + WAIT_LIMIT)
				abort_run($sformatf("master %0d timed out on the %s channel", m,
					write ? "write response" : "read data"));
		end
	endtask

	task automatic add_step(input logic master, input logic write,
			input logic [AXIL_ADDR_W-1:0] addr, input logic [AXIL_DATA_W-1:0] data,
			input axi_resp_t resp, input logic [AXIL_DATA_W-1:0] exp_data);
		step_t s;
		s.master = master;
		s.write = write;
		s.addr = addr;
		s.wdata = data;
		s.resp = resp;
		s.rdata = exp_data;
		steps.push_back(s);
	endtask

	task automatic build_table();
		for (int i = 0; i < SEG_NUM_DIGITS; i++)
			add_step(1'(i % 2), 1'b0, 8'(i * SEG_DIGIT_STRIDE), '0, RESP_OKAY, '0);
		add_step(1'b1, 1'b0, 8'h20, '0, RESP_OKAY, '0);
		add_step(1'b0, 1'b1, 8'h00, 32'h0000_0007, RESP_OKAY, '0);
		add_step(1'b1, 1'b1, 8'h08, 32'hFFFF_FF3A, RESP_OKAY, '0);
		add_step(1'b1, 1'b0, 8'h08, '0, RESP_OKAY, 32'h0000_000A);
		add_step(1'b0, 1'b1, 8'h14, 32'h1234_567C, RESP_OKAY, '0);
		add_step(1'b0, 1'b0, 8'h14, '0, RESP_OKAY, 32'h0000_000C);
		add_step(1'b1, 1'b0, 8'h00, '0, RESP_OKAY, 32'h0000_0007);
		add_step(1'b0, 1'b0, 8'h04, '0, RESP_OKAY, '0);
		add_step(1'b1, 1'b1, 8'h20, 32'h0000_02A5, RESP_OKAY, '0);
		add_step(1'b0, 1'b0, 8'h20, '0, RESP_OKAY, 32'h0000_02A5);
		add_step(1'b0, 1'b1, 8'h20, 32'hFFFF_FC3C, RESP_OKAY, '0);
		add_step(1'b1, 1'b0, 8'h20, '0, RESP_OKAY, 32'h0000_003C);
		add_step(1'b0, 1'b0, 8'h40, '0, RESP_DECERR, '0);
		add_step(1'b1, 1'b1, 8'h80, 32'hFFFF_FFFF, RESP_DECERR, '0);
		add_step(1'b0, 1'b0, 8'hFC, '0, RESP_DECERR, '0);
		add_step(1'b1, 1'b1, 8'h18, 32'h0000_0005, RESP_SLVERR, '0);
		add_step(1'b0, 1'b0, 8'h18, '0, RESP_SLVERR, '0);
		add_step(1'b1, 1'b1, 8'h02, 32'h0000_0009, RESP_SLVERR, '0);
		add_step(1'b0, 1'b1, 8'h24, 32'h0000_03FF, RESP_SLVERR, '0);
		add_step(1'b1, 1'b0, 8'h28, '0, RESP_SLVERR, '0);
		add_step(1'b0, 1'b1, 8'h2C, 32'h0000_0001, RESP_SLVERR, '0);
		add_step(1'b1, 1'b0, 8'h20, '0, RESP_OKAY, 32'h0000_003C);
	endtask

	task automatic run_step(input step_t s);
		axi_resp_t resp;
		logic [AXIL_DATA_W-1:0] rd_val;
		bus_access(int'(s.master), s.write, s.addr, s.wdata, 0, resp, rd_val);
		check_resp($sformatf("m%0d_%s", s.master, s.write ? "bresp_o" : "rresp_o"),
			s.resp, resp);
		if (!s.write)
			check_data($sformatf("m%0d_rdata_o", s.master), s.rdata, rd_val);
		if (s.write && s.resp == RESP_OKAY)
			note_write(s.addr, s.wdata);
		check_outputs();
	endtask

	initial begin
		for (int c = 0; c < RUN_LIMIT; c++)
			@(posedge clk);
		abort_run("simulation ran past its cycle limit");
	end

	initial begin
		axi_resp_t resp_a;
		axi_resp_t resp_b;
		logic [AXIL_DATA_W-1:0] rd_val;
		logic [AXIL_DATA_W-1:0] rd_b;
		integer rv0;
		integer rv1;
		integer rv_hold;
		int hold;
		int tries;
		clk = 1'b0;
		rst = 1'b1;
		sw = '0;
		exp_led = '0;
		for (int i = 0; i < 2; i++) begin
			awvalid[i] = 1'b0;
			wvalid[i] = 1'b0;
			bready[i] = 1'b0;
			arvalid[i] = 1'b0;
			rready[i] = 1'b0;
			awaddr[i] = '0;
			araddr[i] = '0;
			wdata[i] = '0;
			wstrb[i] = {AXIL_STRB_W{1'b1}};
		end
		for (int i = 0; i < SEG_NUM_DIGITS; i++)
			exp_digit[i] = 4'h0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		check_outputs();

		build_table();
		foreach (steps[i])
			run_step(steps[i]);

		// the switch input needs a few cycles through the synchronizer.
		sw = 10'h1B6;
		tries = 0;
		rd_val = '0;
		while (rd_val != 32'h0000_01B6) begin
			bus_access(0, 1'b0, 8'h24, '0, 0, resp_a, rd_val);
			check_resp("m0_rresp_o", RESP_OKAY, resp_a);
			tries++;
			if (rd_val != 32'h0000_01B6 && tries > 8)
				abort_run("switch value never showed up in the switch register");
		end

		rv0 = $random(seed);
		rv1 = $random(seed);
		fork
			bus_access(0, 1'b1, 8'h04, rv0, 0, resp_a, rd_val);
			bus_access(1, 1'b1, 8'h0C, rv1, 0, resp_b, rd_b);
		join
		check_resp("m0_bresp_o", RESP_OKAY, resp_a);
		check_resp("m1_bresp_o", RESP_OKAY, resp_b);
		note_write(8'h04, rv0);
		note_write(8'h0C, rv1);
		check_outputs();

		// master 0 stalls its write response while master 1 asks for the bus.
		rv_hold = $random(seed);
		hold = 2 + int'(rv_hold[2:0]);
		rv0 = $random(seed);
		rv1 = $random(seed);
		fork
			bus_access(0, 1'b1, 8'h10, rv0, hold, resp_a, rd_val);
			begin
				repeat (2) @(negedge clk);
				bus_access(1, 1'b1, 8'h14, rv1, 0, resp_b, rd_b);
			end
		join
		check_resp("m0_bresp_o", RESP_OKAY, resp_a);
		check_resp("m1_bresp_o", RESP_OKAY, resp_b);
		if (addr_time[1] <= resp_time[0])
			abort_run("master 1 got the bus before master 0 took its write response");
		note_write(8'h10, rv0);
		note_write(8'h14, rv1);
		check_outputs();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule : periph_tb

//--- list.f
common/periph_pkg.sv
seg/hex7seg.sv
seg/seg_axil.sv
design/led_axil.sv
design/axil_arbiter.sv
design/axil_decoder.sv
design/periph_top.sv
verif/periph_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the testbench, the exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module periph_tb -f list.f -o periph_sim &&
./obj_dir/periph_sim || exit 1
